//--- flist.f
+incdir+verilog
verilog/csr_map_pkg.sv
verilog/csr_bus_pkg.sv
verilog/csr_access.sv
verilog/csr_trap_ctrl.sv
verilog/csr_machine_regs.sv
verilog/csr_timer.sv
verilog/csr_unit_top.sv
dv/csr_unit_sva.sv
dv/csr_unit_checker.sv
dv/csr_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the CSR unit testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

# the error limit keeps the run going after an assertion failure
verilator --binary --timing --assert -j 0 \
    --top-module csr_unit_tb -f flist.f -o csr_unit_sim \
    && ./obj_dir/csr_unit_sim +verilator+error+limit+100 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "Simulation finished: PASS" sim.log \
    && { echo "result: pass"; exit 0; } \
    || { echo "result: fail"; exit 1; }

//--- dv/csr_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_defines.svh"

module csr_unit_tb
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
;

    localparam logic [1:0] sel_ack  = 2'd0;
    localparam logic [1:0] sel_tpc  = 2'd1;
    localparam logic [1:0] sel_rtrn = 2'd2;
    localparam logic [1:0] sel_pcs  = 2'd3;

    logic                 clk = 1'b0;
    logic                 rst_n;
    csr_cmd_t             cmd;
    logic [`CSR_XLEN-1:0] pc;
    exc_req_t             exc;
    logic                 mret;
    logic                 mexternal;
    logic [`CSR_XLEN-1:0] rdata;
    logic                 trap_ack;
    logic [`CSR_XLEN-1:0] trap_pc;
    logic [`CSR_XLEN-1:0] rtrn_addr;
    logic                 pc_sel;
    logic                 rd_chk;
    logic [`CSR_XLEN-1:0] rd_exp;
    logic                 out_chk;
    logic [1:0]           out_sel;
    logic [`CSR_XLEN-1:0] out_exp;
    logic [3:0]           test_id;
    logic                 test_end;
    logic                 report;
    int                   chk_errors;
    int                   sva_errors;
    integer               seed;
    logic [`CSR_XLEN-1:0] m_scratch;
    logic [`CSR_XLEN-1:0] m_tvec;

    always #10 clk = ~clk;

    csr_unit_top csr_unit_top_i (
        .i_csr_unit_clk       (clk),
        .i_csr_unit_rst_n     (rst_n),
        .i_csr_unit_cmd       (cmd),
        .i_csr_unit_pc        (pc),
        .i_csr_unit_exc       (exc),
        .i_csr_unit_mret      (mret),
        .i_csr_unit_mexternal (mexternal),
        .o_csr_unit_rdata     (rdata),
        .o_csr_unit_trap_ack  (trap_ack),
        .o_csr_unit_trap_pc   (trap_pc),
        .o_csr_unit_rtrn_addr (rtrn_addr),
        .o_csr_unit_pc_sel    (pc_sel)
    );

    csr_unit_checker csr_unit_checker_i (
        .i_csr_unit_clk  (clk),
        .i_rdata         (rdata),
        .i_trap_ack      (trap_ack),
        .i_trap_pc       (trap_pc),
        .i_rtrn_addr     (rtrn_addr),
        .i_pc_sel        (pc_sel),
        .i_rd_chk        (rd_chk),
        .i_rd_exp        (rd_exp),
        .i_out_chk       (out_chk),
        .i_out_sel       (out_sel),
        .i_out_exp       (out_exp),
        .i_test_id       (test_id),
        .i_test_end      (test_end),
        .i_report        (report),
        .i_assert_errors (sva_errors),
        .o_errors        (chk_errors)
    );

    bind csr_trap_ctrl csr_unit_sva csr_unit_sva_i (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_ack            (o_csr_unit_trap_ack),
        .i_take           (o_trap.take),
        .i_mie            (i_mach.mstatus[`CSR_MST_MIE])
    );

    assign sva_errors = csr_unit_top_i.csr_trap_ctrl_i.csr_unit_sva_i.fail_count;

    // reference model of the CSR ops on a full-width register
    function automatic logic [63:0] ref_csr_op(input csr_op_e op, input logic [63:0] old,
                                               input logic [63:0] src);
        case (op)
            csr_op_rw: ref_csr_op = src;
            csr_op_rs: ref_csr_op = old | src;
            csr_op_rc: ref_csr_op = old & ~src;
            default:   ref_csr_op = old;
        endcase
    endfunction

    function automatic logic [63:0] ref_cause(input logic irq, input logic [62:0] code);
        ref_cause = {irq, code};
    endfunction

    // vectored mode moves interrupts only
    function automatic logic [63:0] ref_trap_pc(input logic [63:0] tvec, input logic [63:0] cause);
        logic [63:0] base;
        base = {tvec[63:1], 1'b0};
        if (tvec[0] && cause[63])
            ref_trap_pc = base + 64'(cause[62:0]) * 64'd4;
        else
            ref_trap_pc = base;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        rd_chk   = 1'b0;
        out_chk  = 1'b0;
        test_end = 1'b0;
    endtask

    task automatic expect_rd(input logic [11:0] addr, input logic [63:0] exp);
        cmd.addr = addr;
        rd_chk   = 1'b1;
        rd_exp   = exp;
    endtask

    task automatic expect_out(input logic [1:0] sel, input logic [63:0] exp);
        out_chk = 1'b1;
        out_sel = sel;
        out_exp = exp;
    endtask

    task automatic csr_write(input csr_op_e op, input logic [11:0] addr, input logic [63:0] src);
        cmd.wen  = 1'b1;
        cmd.op   = op;
        cmd.addr = addr;
        cmd.src  = src;
        next_cycle();
        cmd.wen = 1'b0;
        cmd.op  = csr_op_none;
    endtask

    task automatic end_test();
        test_end = 1'b1;
        next_cycle();
    endtask

    task automatic finish_run(input logic timed_out);
        report = 1'b1;
        #1;
        if (!timed_out && chk_errors == 0 && sva_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic wait_ack(input int limit);
        int n;
        n = 0;
        while (!trap_ack && n < limit)
        begin
            next_cycle();
            n++;
        end
        if (!trap_ack)
        begin
            $display("timeout: no trap ack after %0d cycles in test %0d", limit, test_id);
            finish_run(1'b1);
        end
    endtask

    // request edge, ack cycle, then the stored cause, epc and tval
    task automatic exception_case(input logic [5:0] flags, input logic [62:0] code,
                                  input logic [63:0] epc);
        logic [63:0] fault;
        logic [63:0] cause;
        fault = {$random(seed), $random(seed)};
        cause = ref_cause(1'b0, code);
        pc    = epc;
        exc   = {flags, fault};
        expect_out(sel_ack, 64'd0);
        next_cycle();
        exc = '0;
        expect_out(sel_ack, 64'd1);
        expect_rd(csr_mcause, cause);
        next_cycle();
        expect_out(sel_tpc, ref_trap_pc(m_tvec, cause));
        expect_rd(csr_mepc, epc);
        next_cycle();
        expect_rd(csr_mtval, (code == 63'd5 || code == 63'd7) ? fault : 64'd0);
        next_cycle();
    endtask

    initial
    begin
        logic [31:0] r;
        int          k;
        csr_op_e     op;
        logic [63:0] src;
        logic [63:0] cause;
        logic [63:0] now;
        seed      = 32'he2c7_22dc;
        rst_n     = 1'b0;
        cmd       = '0;
        pc        = '0;
        exc       = '0;
        mret      = 1'b0;
        mexternal = 1'b0;
        rd_chk    = 1'b0;
        rd_exp    = '0;
        out_chk   = 1'b0;
        out_sel   = sel_ack;
        out_exp   = '0;
        test_id   = 4'd0;
        test_end  = 1'b0;
        report    = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        test_id = 4'd1;
        expect_rd(csr_mstatus, 64'h1800);
        expect_out(sel_ack, 64'd0);
        next_cycle();
        expect_rd(csr_misa, `CSR_MISA_VAL);
        next_cycle();
        expect_rd(csr_mvendorid, 64'd0);
        next_cycle();
        expect_rd(csr_mhartid, 64'd0);
        next_cycle();
        end_test();

        test_id   = 4'd2;
        m_scratch = '0;
        m_tvec    = '0;
        for (int i = 0; i < 24; i++)
        begin
            r   = $random(seed);
            k   = r % 3;
            op  = (k == 0) ? csr_op_rw : (k == 1) ? csr_op_rs : csr_op_rc;
            src = {$random(seed), $random(seed)};
            if (r[8])
            begin
                csr_write(op, csr_mtvec, src);
                m_tvec = ref_csr_op(op, m_tvec, src);
                expect_rd(csr_mtvec, m_tvec);
            end
            else
            begin
                csr_write(op, csr_mscratch, src);
                m_scratch = ref_csr_op(op, m_scratch, src);
                expect_rd(csr_mscratch, m_scratch);
            end
            next_cycle();
        end
        end_test();

        test_id = 4'd3;
        m_tvec  = 64'h1000;     // direct mode
        csr_write(csr_op_rw, csr_mtvec, m_tvec);
        exception_case(6'b100000, 63'd2, 64'h8000_0100);
        exception_case(6'b010000, 63'd0, 64'h8000_0104);
        exception_case(6'b001000, 63'd11, 64'h8000_0108);
        exception_case(6'b000100, 63'd3, 64'h8000_010c);
        exception_case(6'b000010, 63'd7, 64'h8000_0110);
        exception_case(6'b000001, 63'd5, 64'h8000_0114);
        exception_case(6'b100001, 63'd2, 64'h8000_0118);     // illegal over load fault
        exception_case(6'b000011, 63'd7, 64'h8000_011c);
        exception_case(6'b001100, 63'd11, 64'h8000_0120);
        end_test();

        test_id = 4'd4;
        m_tvec  = 64'h2001;     // vectored, base 0x2000
        csr_write(csr_op_rw, csr_mtvec, m_tvec);
        csr_write(csr_op_rw, csr_mie, 64'h800);
        csr_write(csr_op_rs, csr_mstatus, 64'h8);
        pc        = 64'h8000_1234;
        mexternal = 1'b1;
        wait_ack(20);
        mexternal = 1'b0;
        cause     = ref_cause(1'b1, 63'd11);
        expect_out(sel_tpc, ref_trap_pc(m_tvec, cause));
        expect_rd(csr_mcause, cause);
        next_cycle();
        expect_rd(csr_mstatus, 64'h1880);   // MIE 0, MPIE 1
        next_cycle();
        expect_rd(csr_mepc, 64'h8000_1234);
        next_cycle();
        end_test();

        test_id = 4'd5;
        expect_out(sel_rtrn, 64'h8000_1234);
        next_cycle();
        mret = 1'b1;
        expect_out(sel_pcs, 64'd1);
        expect_rd(csr_mstatus, 64'h1880);
        next_cycle();
        mret = 1'b0;
        expect_out(sel_pcs, 64'd0);
        expect_rd(csr_mstatus, 64'h1888);
        next_cycle();
        end_test();

        test_id  = 4'd6;
        cmd.addr = csr_cycle;
        next_cycle();
        now = rdata;
        csr_write(csr_op_rw, csr_mtimecmp, now + 64'd40);
        csr_write(csr_op_rw, csr_mie, 64'h80);
        wait_ack(100);
        cause = ref_cause(1'b1, 63'd7);
        expect_out(sel_tpc, ref_trap_pc(m_tvec, cause));
        expect_rd(csr_mcause, cause);
        next_cycle();
        end_test();

        finish_run(1'b0);
    end

endmodule

`default_nettype wire

//--- dv/csr_unit_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_defines.svh"

module csr_unit_checker
(
    input  logic                    i_csr_unit_clk,
    input  logic [`CSR_XLEN-1:0]    i_rdata,
    input  logic                    i_trap_ack,
    input  logic [`CSR_XLEN-1:0]    i_trap_pc,
    input  logic [`CSR_XLEN-1:0]    i_rtrn_addr,
    input  logic                    i_pc_sel,
    input  logic                    i_rd_chk,
    input  logic [`CSR_XLEN-1:0]    i_rd_exp,
    input  logic                    i_out_chk,
    input  logic [1:0]              i_out_sel,
    input  logic [`CSR_XLEN-1:0]    i_out_exp,
    input  logic [3:0]              i_test_id,
    input  logic                    i_test_end,
    input  logic                    i_report,
    input  int                      i_assert_errors,
    output int                      o_errors
);

    int                   errors = 0;
    int                   test_errs = 0;
    int                   checks = 0;
    int                   tests = 0;
    logic [`CSR_XLEN-1:0] out_act;

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    test_name = "reset_state";
            4'd2:    test_name = "csr_ops";
            4'd3:    test_name = "exceptions_direct";
            4'd4:    test_name = "ext_irq_vectored";
            4'd5:    test_name = "mret";
            4'd6:    test_name = "timer_irq";
            default: test_name = "unknown";
        endcase
    endfunction

    function automatic string out_name(input logic [1:0] sel);
        case (sel)
            2'd0:    out_name = "trap_ack";
            2'd1:    out_name = "trap_pc";
            2'd2:    out_name = "rtrn_addr";
            default: out_name = "pc_sel";
        endcase
    endfunction

    always_comb
    begin
        case (i_out_sel)
            2'd0:    out_act = {63'd0, i_trap_ack};    // single bits zero extended
            2'd1:    out_act = i_trap_pc;
            2'd2:    out_act = i_rtrn_addr;
            default: out_act = {63'd0, i_pc_sel};
        endcase
    end

    // pre-edge values, stable since the falling edge
    always @(posedge i_csr_unit_clk)
    begin
        if (i_rd_chk)
        begin
            checks++;
            if (i_rdata !== i_rd_exp)
            begin
                $display("Fail %s rdata: expected %h, actual %h",
                         test_name(i_test_id), i_rd_exp, i_rdata);
                errors++;
                test_errs++;
            end
        end
        if (i_out_chk)
        begin
            checks++;
            if (out_act !== i_out_exp)
            begin
                $display("Fail %s %s: expected %h, actual %h",
                         test_name(i_test_id), out_name(i_out_sel), i_out_exp, out_act);
                errors++;
                test_errs++;
            end
        end
        if (i_test_end)
        begin
            $display("test %s %s, %0d errors", test_name(i_test_id),
                     (test_errs == 0) ? "passed" : "failed", test_errs);
            tests++;
            test_errs = 0;
        end
    end

    always @(posedge i_report)
        $display("tests %0d, checks %0d, check errors %0d, assertion errors %0d",
                 tests, checks, errors, i_assert_errors);

    assign o_errors = errors;

endmodule

`default_nettype wire

//--- dv/csr_unit_sva.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_sva
(
    input  logic    i_csr_unit_clk,
    input  logic    i_csr_unit_rst_n,
    input  logic    i_ack,
    input  logic    i_take,
    input  logic    i_mie
);

    int fail_count = 0;     // read by the testbench

    ack_one_cycle: assert property (@(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        i_ack |=> !i_ack)
    else
    begin
        $error("trap ack held high for more than one cycle");
        fail_count++;
    end

    // every ack follows an accepted trap
    ack_after_take: assert property (@(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        i_ack |-> $past(i_take))
    else
    begin
        $error("trap ack without an accepted trap");
        fail_count++;
    end

    ack_mie_clear: assert property (@(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        i_ack |-> !i_mie)
    else
    begin
        $error("mstatus.MIE set during the trap ack cycle");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- verilog/csr_unit_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_defines.svh"

module csr_unit_top
    import csr_bus_pkg::*;
(
    input  logic                    i_csr_unit_clk,
    input  logic                    i_csr_unit_rst_n,
    input  csr_cmd_t                i_csr_unit_cmd,
    input  logic [`CSR_XLEN-1:0]    i_csr_unit_pc,
    input  exc_req_t                i_csr_unit_exc,
    input  logic                    i_csr_unit_mret,
    input  logic                    i_csr_unit_mexternal,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_rdata,
    output logic                    o_csr_unit_trap_ack,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_trap_pc,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_rtrn_addr,
    output logic                    o_csr_unit_pc_sel
);

    csr_wr_t        wr;
    mach_state_t    mach;
    timer_state_t   timer;
    trap_entry_t    trap;

    csr_access csr_access_i (
        .i_csr_unit_cmd       (i_csr_unit_cmd),
        .i_mach               (mach),
        .i_timer              (timer),
        .o_csr_unit_rdata     (o_csr_unit_rdata),
        .o_wr                 (wr)
    );

    csr_trap_ctrl csr_trap_ctrl_i (
        .i_csr_unit_clk       (i_csr_unit_clk),
        .i_csr_unit_rst_n     (i_csr_unit_rst_n),
        .i_csr_unit_pc        (i_csr_unit_pc),
        .i_csr_unit_exc       (i_csr_unit_exc),
        .i_mach               (mach),
        .i_timer              (timer),
        .o_trap               (trap),
        .o_csr_unit_trap_ack  (o_csr_unit_trap_ack)
    );

    csr_machine_regs csr_machine_regs_i (
        .i_csr_unit_clk       (i_csr_unit_clk),
        .i_csr_unit_rst_n     (i_csr_unit_rst_n),
        .i_wr                 (wr),
        .i_trap               (trap),
        .i_csr_unit_mret      (i_csr_unit_mret),
        .o_mach               (mach),
        .o_csr_unit_trap_pc   (o_csr_unit_trap_pc),
        .o_csr_unit_rtrn_addr (o_csr_unit_rtrn_addr)
    );

    csr_timer csr_timer_i (
        .i_csr_unit_clk       (i_csr_unit_clk),
        .i_csr_unit_rst_n     (i_csr_unit_rst_n),
        .i_wr                 (wr),
        .i_csr_unit_mexternal (i_csr_unit_mexternal),
        .o_timer              (timer)
    );

    // fetch redirect on trap target or return address
    assign o_csr_unit_pc_sel = o_csr_unit_trap_ack | i_csr_unit_mret;

endmodule

`default_nettype wire

//--- verilog/csr_timer.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_defines.svh"

module csr_timer
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic            i_csr_unit_clk,
    input  logic            i_csr_unit_rst_n,
    input  csr_wr_t         i_wr,
    input  logic            i_csr_unit_mexternal,
    output timer_state_t    o_timer
);

    logic [`CSR_XLEN-1:0] counter;
    logic [`CSR_XLEN-1:0] mtimecmp;
    logic                 meip_q;
    logic                 mtip_q;

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            counter  <= '0;
            mtimecmp <= '0;
            meip_q   <= 1'b0;
            mtip_q   <= 1'b0;
        end
        else
        begin
            counter <= counter + 64'd1;   // cycle and time share it
            if (i_wr.strobe && (i_wr.addr == csr_mtimecmp))
                mtimecmp <= i_wr.data;
            meip_q <= i_csr_unit_mexternal;
            mtip_q <= (counter >= mtimecmp);
        end
    end

    always_comb
    begin
        o_timer                   = '0;
        o_timer.counter           = counter;
        o_timer.mtimecmp          = mtimecmp;
        o_timer.mip[`CSR_IRQ_MTI] = mtip_q;
        o_timer.mip[`CSR_IRQ_MEI] = meip_q;
    end

endmodule

`default_nettype wire

//--- verilog/csr_machine_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_defines.svh"

module csr_machine_regs
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic                    i_csr_unit_clk,
    input  logic                    i_csr_unit_rst_n,
    input  csr_wr_t                 i_wr,
    input  trap_entry_t             i_trap,
    input  logic                    i_csr_unit_mret,
    output mach_state_t             o_mach,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_trap_pc,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_rtrn_addr
);

    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] tvec_base;

    // trap entry beats mret, mret beats a CSR write
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mstatus  <= `CSR_MSTATUS_RST;
            mie      <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
        end
        else if (i_trap.take)
        begin
            mepc                  <= {i_trap.epc[`CSR_XLEN-1:1], 1'b0};
            mcause                <= {i_trap.interrupt, i_trap.code};
            mtval                 <= i_trap.tval;
            mstatus[`CSR_MST_MPIE] <= mstatus[`CSR_MST_MIE];
            mstatus[`CSR_MST_MIE]  <= 1'b0;
            mstatus[`CSR_MST_MPP]  <= priv_m;     // hart never leaves M
        end
        else if (i_csr_unit_mret)
        begin
            mstatus[`CSR_MST_MIE]  <= mstatus[`CSR_MST_MPIE];
            mstatus[`CSR_MST_MPIE] <= 1'b1;
            mstatus[`CSR_MST_MPP]  <= priv_m;
        end
        else if (i_wr.strobe)
        begin
            case (i_wr.addr)
                csr_mstatus:
                begin
                    mstatus[`CSR_MST_MIE]  <= i_wr.data[`CSR_MST_MIE];
                    mstatus[`CSR_MST_MPIE] <= i_wr.data[`CSR_MST_MPIE];
                    mstatus[`CSR_MST_MPP]  <= priv_m;   // only legal value
                end
                csr_mie:
                begin
                    mie[`CSR_IRQ_MTI] <= i_wr.data[`CSR_IRQ_MTI];
                    mie[`CSR_IRQ_MEI] <= i_wr.data[`CSR_IRQ_MEI];
                end
                csr_mtvec:      mtvec    <= i_wr.data;
                csr_mscratch:   mscratch <= i_wr.data;
                csr_mepc:       mepc     <= {i_wr.data[`CSR_XLEN-1:1], 1'b0};
                csr_mcause:     mcause   <= i_wr.data;
                csr_mtval:      mtval    <= i_wr.data;
                default:        ;   // mtimecmp lives in the timer
            endcase
        end
    end

    assign tvec_base = {mtvec[`CSR_XLEN-1:1], 1'b0};

    // vectored mode offsets interrupts only
    assign o_csr_unit_trap_pc = (mtvec[0] && mcause[`CSR_XLEN-1])
                              ? tvec_base + {mcause[`CSR_XLEN-3:0], 2'b00}
                              : tvec_base;

    assign o_csr_unit_rtrn_addr = mepc;

    assign o_mach.mstatus  = mstatus;
    assign o_mach.mie      = mie;
    assign o_mach.mtvec    = mtvec;
    assign o_mach.mepc     = mepc;
    assign o_mach.mcause   = mcause;
    assign o_mach.mtval    = mtval;
    assign o_mach.mscratch = mscratch;

endmodule

`default_nettype wire

//--- verilog/csr_trap_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_defines.svh"

module csr_trap_ctrl
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic                    i_csr_unit_clk,
    input  logic                    i_csr_unit_rst_n,
    input  logic [`CSR_XLEN-1:0]    i_csr_unit_pc,
    input  exc_req_t                i_csr_unit_exc,
    input  mach_state_t             i_mach,
    input  timer_state_t            i_timer,
    output trap_entry_t             o_trap,
    output logic                    o_csr_unit_trap_ack
);

    typedef enum logic {
        st_idle,
        st_busy
    } trap_state_e;

    trap_state_e            state;
    logic                   ext_irq;
    logic                   tmr_irq;
    logic                   trap_req;
    logic                   is_irq;
    logic [`CSR_CODE_W-1:0] code;
    logic [`CSR_XLEN-1:0]   tval;

    assign ext_irq = i_mach.mstatus[`CSR_MST_MIE] & i_mach.mie[`CSR_IRQ_MEI]
                   & i_timer.mip[`CSR_IRQ_MEI];
    assign tmr_irq = i_mach.mstatus[`CSR_MST_MIE] & i_mach.mie[`CSR_IRQ_MTI]
                   & i_timer.mip[`CSR_IRQ_MTI];

    // fixed priority, interrupts first
    always_comb
    begin
        trap_req = 1'b1;
        is_irq   = 1'b0;
        code     = '0;
        tval     = '0;
        if (ext_irq)
        begin
            is_irq = 1'b1;
            code   = irq_m_external;
        end
        else if (tmr_irq)
        begin
            is_irq = 1'b1;
            code   = irq_m_timer;
        end
        else if (i_csr_unit_exc.illegal)
            code = exc_illegal;
        else if (i_csr_unit_exc.misaligned)
            code = exc_misaligned;
        else if (i_csr_unit_exc.ecall)
            code = exc_ecall;
        else if (i_csr_unit_exc.ebreak)
            code = exc_ebreak;
        else if (i_csr_unit_exc.store_fault)
        begin
            code = exc_store_fault;
            tval = i_csr_unit_exc.fault_addr;
        end
        else if (i_csr_unit_exc.load_fault)
        begin
            code = exc_load_fault;
            tval = i_csr_unit_exc.fault_addr;
        end
        else
            trap_req = 1'b0;
    end

    assign o_trap.take      = trap_req && (state == st_idle);   // blocked in the ack cycle
    assign o_trap.interrupt = is_irq;
    assign o_trap.code      = code;
    assign o_trap.epc       = i_csr_unit_pc;
    assign o_trap.tval      = tval;

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
            state <= st_idle;
        else if (state == st_busy)
            state <= st_idle;
        else if (o_trap.take)
            state <= st_busy;
    end

    assign o_csr_unit_trap_ack = (state == st_busy);

endmodule

`default_nettype wire

//--- verilog/csr_access.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_defines.svh"

module csr_access
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
(
    input  csr_cmd_t                i_csr_unit_cmd,
    input  mach_state_t             i_mach,
    input  timer_state_t            i_timer,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_rdata,
    output csr_wr_t                 o_wr
);

    logic [`CSR_XLEN-1:0] op_result;
    logic                 writable;

    // read mux, same cycle as the address
    always_comb
    begin
        case (i_csr_unit_cmd.addr)
            csr_misa:       o_csr_unit_rdata = `CSR_MISA_VAL;
            csr_mstatus:    o_csr_unit_rdata = i_mach.mstatus;
            csr_mie:        o_csr_unit_rdata = i_mach.mie;
            csr_mip:        o_csr_unit_rdata = i_timer.mip;
            csr_mtvec:      o_csr_unit_rdata = i_mach.mtvec;
            csr_mscratch:   o_csr_unit_rdata = i_mach.mscratch;
            csr_mepc:       o_csr_unit_rdata = i_mach.mepc;
            csr_mcause:     o_csr_unit_rdata = i_mach.mcause;
            csr_mtval:      o_csr_unit_rdata = i_mach.mtval;
            csr_mtimecmp:   o_csr_unit_rdata = i_timer.mtimecmp;
            csr_cycle,
            csr_time:       o_csr_unit_rdata = i_timer.counter;
            default:        o_csr_unit_rdata = '0;  // ids and unknown addresses
        endcase
    end

    always_comb
    begin
        case (i_csr_unit_cmd.op)
            csr_op_rw:  op_result = i_csr_unit_cmd.src;
            csr_op_rs:  op_result = o_csr_unit_rdata | i_csr_unit_cmd.src;
            csr_op_rc:  op_result = o_csr_unit_rdata & ~i_csr_unit_cmd.src;
            default:    op_result = o_csr_unit_rdata;
        endcase
    end

    // mip, misa, counter and the id regs are read only
    always_comb
    begin
        case (i_csr_unit_cmd.addr)
            csr_mstatus,
            csr_mie,
            csr_mtvec,
            csr_mscratch,
            csr_mepc,
            csr_mcause,
            csr_mtval,
            csr_mtimecmp:   writable = 1'b1;
            default:        writable = 1'b0;
        endcase
    end

    assign o_wr.strobe = i_csr_unit_cmd.wen && (i_csr_unit_cmd.op != csr_op_none) && writable;
    assign o_wr.addr   = i_csr_unit_cmd.addr;
    assign o_wr.data   = op_result;

endmodule

`default_nettype wire

//--- verilog/csr_bus_pkg.sv
`default_nettype none
`include "csr_defines.svh"

package csr_bus_pkg;

    import csr_map_pkg::*;

    // one CSR instruction from the pipeline
    typedef struct packed {
        logic                     wen;
        csr_op_e                  op;
        logic [`CSR_ADDR_W-1:0]   addr;
        logic [`CSR_XLEN-1:0]     src;
    } csr_cmd_t;

    // write after op resolution
    typedef struct packed {
        logic                     strobe;
        logic [`CSR_ADDR_W-1:0]   addr;
        logic [`CSR_XLEN-1:0]     data;
    } csr_wr_t;

    typedef struct packed {
        logic                     illegal;
        logic                     misaligned;
        logic                     ecall;
        logic                     ebreak;
        logic                     store_fault;
        logic                     load_fault;
        logic [`CSR_XLEN-1:0]     fault_addr;   // only meaningful for the access faults
    } exc_req_t;

    typedef struct packed {
        logic                     take;
        logic                     interrupt;
        logic [`CSR_CODE_W-1:0]   code;
        logic [`CSR_XLEN-1:0]     epc;
        logic [`CSR_XLEN-1:0]     tval;
    } trap_entry_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0]     mstatus;
        logic [`CSR_XLEN-1:0]     mie;
        logic [`CSR_XLEN-1:0]     mtvec;
        logic [`CSR_XLEN-1:0]     mepc;
        logic [`CSR_XLEN-1:0]     mcause;
        logic [`CSR_XLEN-1:0]     mtval;
        logic [`CSR_XLEN-1:0]     mscratch;
    } mach_state_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0]     counter;
        logic [`CSR_XLEN-1:0]     mtimecmp;
        logic [`CSR_XLEN-1:0]     mip;          // bits 7 and 11 only
    } timer_state_t;

endpackage

`default_nettype wire

//--- verilog/csr_map_pkg.sv
`default_nettype none
`include "csr_defines.svh"

package csr_map_pkg;

    // machine-mode CSR addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_mip       = 12'h344,
        csr_mtimecmp  = 12'hbbf,    // memory-mapped on most cores, a CSR here
        csr_cycle     = 12'hc00,
        csr_time      = 12'hc01,
        csr_mvendorid = 12'hf11,
        csr_marchid   = 12'hf12,
        csr_mimpid    = 12'hf13,
        csr_mhartid   = 12'hf14
    } csr_addr_e;

    typedef enum logic [1:0] {
        csr_op_none = 2'h0,
        csr_op_rw   = 2'h1,
        csr_op_rs   = 2'h2,
        csr_op_rc   = 2'h3
    } csr_op_e;

    typedef enum logic [`CSR_CODE_W-1:0] {
        exc_misaligned  = 63'd0,
        exc_illegal     = 63'd2,
        exc_ebreak      = 63'd3,
        exc_load_fault  = 63'd5,
        exc_store_fault = 63'd7,
        exc_ecall       = 63'd11
    } exc_code_e;

    typedef enum logic [`CSR_CODE_W-1:0] {
        irq_m_timer    = 63'd7,
        irq_m_external = 63'd11
    } irq_code_e;

    localparam logic [1:0] priv_m = 2'b11;

endpackage

`default_nettype wire

//--- verilog/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// datapath and CSR field widths
`define CSR_XLEN            64
`define CSR_ADDR_W          12
`define CSR_CODE_W          63

// misa: MXL=2, extensions I M A C
`define CSR_MISA_VAL        64'h8000_0000_0000_1105

// mstatus comes out of reset with MPP = M
`define CSR_MSTATUS_RST     64'h0000_0000_0000_1800

// mstatus field positions
`define CSR_MST_MIE         3
`define CSR_MST_MPIE        7
`define CSR_MST_MPP         12:11

// bit positions shared by mie and mip
`define CSR_IRQ_MTI         7
`define CSR_IRQ_MEI         11

`endif
